// File: hw/soc_params.svh
// --------------------
// System parameters: memory map, bus widths, SRAM depth,
// debug hold-off length and boot ROM image.
// Include wherever one of these values is needed.
// --------------------
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 64
`define SOC_BE_W   8

// Memory map
`define SOC_ROM_BASE   32'h0001_0000
`define SOC_ROM_LEN    32'h0000_0040
`define SOC_CLINT_BASE 32'h0200_0000
`define SOC_CLINT_LEN  32'h0000_C000
`define SOC_SRAM_BASE  32'h8000_0000
`define SOC_SRAM_WORDS 1024
`define SOC_SRAM_LEN   (`SOC_SRAM_WORDS * 8)

// CLINT register offsets
`define SOC_CLINT_MSIP     32'h0000_0000
`define SOC_CLINT_MTIMECMP 32'h0000_4000
`define SOC_CLINT_MTIME    32'h0000_BFF8

// Cycles after power-on reset with debug requests masked
`define SOC_DBG_HOLDOFF 500

`define SOC_BOOT_IMAGE '{64'h0000_0297_0202_8293, 64'h0102_8067_0000_0013, \
  64'h3020_0073_0000_0013, 64'h0010_0513_0000_0593, 64'h1050_0073_ffdf_f06f, \
  64'hdead_beef_0bad_cafe, 64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210}

`endif

// File: hw/soc_pkg.sv
// --------------------
// Shared bus types for the system shell.
// Modules pull these in with a wildcard import.
// --------------------
`default_nettype none

`include "soc_params.svh"

package soc_pkg;

  // Word view of an address, used by the memories
  typedef struct packed {
    logic [`SOC_ADDR_W-$clog2(`SOC_BE_W)-1:0] word_idx;
    logic [$clog2(`SOC_BE_W)-1:0]             byte_off;
  } bus_word_t;

  // One address word, decoded as a byte address or as word index plus offset
  typedef union packed {
    logic [`SOC_ADDR_W-1:0] byte_addr;
    bus_word_t              word;
  } bus_addr_u;

  typedef struct packed {
    logic                   we;
    bus_addr_u              addr;
    logic [`SOC_BE_W-1:0]   be;
    logic [`SOC_DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [`SOC_DATA_W-1:0] rdata;
    logic                   err;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_SRAM,
    TGT_CLINT,
    TGT_NONE
  } target_e;

endpackage

`default_nettype wire

// File: hw/soc_rst_gen.sv
// --------------------
// System reset generator. Power-on reset and the debug
// system reset request both assert the output at once;
// release follows two clock edges after both are clear.
// --------------------
`timescale 1ns/1ps
`default_nettype none

module soc_rst_gen (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic rst_no
);

  logic       rst_comb_n;
  logic [1:0] sync_q;

  // Either source holds the system in reset
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_no = sync_q[1];

endmodule

`default_nettype wire

// File: hw/soc_addr_decode.sv
// --------------------
// Address decoder. Strobes one target per request from the
// base/length map, forwards the request as is, and muxes
// the registered target read data one cycle later.
// Unmapped addresses answer with err set.
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module soc_addr_decode import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  bus_req_t               bus_req_i,
  output logic                   rom_req_o,
  output logic                   sram_req_o,
  output logic                   clint_req_o,
  output bus_req_t               bus_req_o,
  input  logic [`SOC_DATA_W-1:0] rom_rdata_i,
  input  logic [`SOC_DATA_W-1:0] sram_rdata_i,
  input  logic [`SOC_DATA_W-1:0] clint_rdata_i,
  output logic                   rsp_valid_o,
  output bus_rsp_t               bus_rsp_o
);

  logic [`SOC_ADDR_W-1:0] addr;
  target_e                tgt;
  target_e                tgt_q;
  logic                   valid_q;
  logic                   we_q;

  function automatic logic in_window(input logic [`SOC_ADDR_W-1:0] a,
                                     input logic [`SOC_ADDR_W-1:0] base,
                                     input logic [`SOC_ADDR_W-1:0] len);
    return (a >= base) && (a < base + len);
  endfunction

  assign addr = bus_req_i.addr.byte_addr;

  always_comb begin
    tgt = TGT_NONE;
    if (in_window(addr, `SOC_ROM_BASE, `SOC_ROM_LEN)) tgt = TGT_ROM;
    else if (in_window(addr, `SOC_SRAM_BASE, `SOC_SRAM_LEN)) tgt = TGT_SRAM;
    else if (in_window(addr, `SOC_CLINT_BASE, `SOC_CLINT_LEN)) tgt = TGT_CLINT;
  end

  assign rom_req_o   = req_i && (tgt == TGT_ROM);
  assign sram_req_o  = req_i && (tgt == TGT_SRAM);
  assign clint_req_o = req_i && (tgt == TGT_CLINT);
  assign bus_req_o   = bus_req_i;

  // Lines up with the one-cycle target reads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      tgt_q   <= TGT_NONE;
      we_q    <= 1'b0;
    end else begin
      valid_q <= req_i;
      tgt_q   <= tgt;
      we_q    <= bus_req_i.we;
    end
  end

  // --------------------
  // Response mux
  // --------------------
  always_comb begin
    unique case (tgt_q)
      TGT_ROM:   bus_rsp_o.rdata = rom_rdata_i;
      TGT_SRAM:  bus_rsp_o.rdata = sram_rdata_i;
      TGT_CLINT: bus_rsp_o.rdata = clint_rdata_i;
      default:   bus_rsp_o.rdata = '0;
    endcase
    // Writes answer with zero data
    if (we_q) bus_rsp_o.rdata = '0;
    bus_rsp_o.err = valid_q && (tgt_q == TGT_NONE);
  end

  assign rsp_valid_o = valid_q;

endmodule

`default_nettype wire

// File: hw/soc_bootrom.sv
// --------------------
// Boot ROM holding the fixed boot image.
// Read data is registered one cycle after the request;
// the index wraps over the 8 image words.
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module soc_bootrom import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  bus_addr_u              addr_i,
  output logic [`SOC_DATA_W-1:0] rdata_o
);

  localparam int unsigned rom_words = 8;

  localparam logic [`SOC_DATA_W-1:0] image [rom_words] = `SOC_BOOT_IMAGE;

  logic [$clog2(rom_words)-1:0] idx;
  logic [`SOC_DATA_W-1:0]       rdata_q;

  assign idx = addr_i.word.word_idx[$clog2(rom_words)-1:0];

  // Writes land here too and simply read the word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i) begin
      rdata_q <= image[idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: hw/soc_sram.sv
// --------------------
// Single-port SRAM with byte enables and registered read.
// Runs on power-on reset only, so a debug system reset
// leaves its contents in place.
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module soc_sram import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  bus_req_t               bus_req_i,
  output logic [`SOC_DATA_W-1:0] rdata_o
);

  localparam int unsigned idx_w = $clog2(`SOC_SRAM_WORDS);

  logic [`SOC_DATA_W-1:0] mem [`SOC_SRAM_WORDS];
  logic [idx_w-1:0]       idx;
  logic [`SOC_DATA_W-1:0] rdata_q;

  assign idx = bus_req_i.addr.word.word_idx[idx_w-1:0];

  // Byte merge on write
  always_ff @(posedge clk_i) begin
    if (req_i && bus_req_i.we) begin
      for (int i = 0; i < `SOC_BE_W; i++) begin
        if (bus_req_i.be[i]) begin
          mem[idx][8*i +: 8] <= bus_req_i.wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i) begin
      rdata_q <= mem[idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: hw/soc_clint.sv
// --------------------
// Core-local interruptor: msip, mtimecmp and mtime.
// mtime counts synchronized rtc rising edges; a bus write
// to mtime wins over the tick in the same cycle.
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module soc_clint import soc_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rtc_i,
  input  logic                   req_i,
  input  bus_req_t               bus_req_i,
  output logic [`SOC_DATA_W-1:0] rdata_o,
  output logic                   timer_irq_o,
  output logic                   ipi_o
);

  localparam logic [`SOC_ADDR_W-1:0] msip_off     = `SOC_CLINT_MSIP;
  localparam logic [`SOC_ADDR_W-1:0] mtimecmp_off = `SOC_CLINT_MTIMECMP;
  localparam logic [`SOC_ADDR_W-1:0] mtime_off    = `SOC_CLINT_MTIME;

  logic [`SOC_ADDR_W-1:0] offset;
  logic                   sel_msip, sel_mtimecmp, sel_mtime;
  logic                   wr;
  logic [2:0]             rtc_q;
  logic                   rtc_edge;
  logic                   msip_q;
  logic [`SOC_DATA_W-1:0] mtimecmp_q, mtime_q, rdata_q;

  function automatic logic [`SOC_DATA_W-1:0] merge_bytes(
    input logic [`SOC_DATA_W-1:0] old_val,
    input logic [`SOC_DATA_W-1:0] new_val,
    input logic [`SOC_BE_W-1:0]   be
  );
    logic [`SOC_DATA_W-1:0] res;
    res = old_val;
    for (int i = 0; i < `SOC_BE_W; i++) begin
      if (be[i]) res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  // Word-aligned register select
  assign offset       = bus_req_i.addr.byte_addr - `SOC_CLINT_BASE;
  assign sel_msip     = offset[`SOC_ADDR_W-1:3] == msip_off[`SOC_ADDR_W-1:3];
  assign sel_mtimecmp = offset[`SOC_ADDR_W-1:3] == mtimecmp_off[`SOC_ADDR_W-1:3];
  assign sel_mtime    = offset[`SOC_ADDR_W-1:3] == mtime_off[`SOC_ADDR_W-1:3];
  assign wr           = req_i && bus_req_i.we;

  // Two-flop sync plus one for edge detect
  assign rtc_edge = rtc_q[1] & ~rtc_q[2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q      <= '0;
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
      rdata_q    <= '0;
    end else begin
      rtc_q <= {rtc_q[1:0], rtc_i};
      if (wr && sel_msip && bus_req_i.be[0]) msip_q <= bus_req_i.wdata[0];
      if (wr && sel_mtimecmp) begin
        mtimecmp_q <= merge_bytes(mtimecmp_q, bus_req_i.wdata, bus_req_i.be);
      end
      if (wr && sel_mtime) begin
        mtime_q <= merge_bytes(mtime_q, bus_req_i.wdata, bus_req_i.be);
      end else if (rtc_edge) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (req_i) begin
        if (sel_msip) rdata_q <= {{(`SOC_DATA_W-1){1'b0}}, msip_q};
        else if (sel_mtimecmp) rdata_q <= mtimecmp_q;
        else if (sel_mtime) rdata_q <= mtime_q;
        else rdata_q <= '0;
      end
    end
  end

  assign rdata_o     = rdata_q;
  assign timer_irq_o = mtime_q >= mtimecmp_q;
  assign ipi_o       = msip_q;

endmodule

`default_nettype wire

// File: hw/soc_debug_gate.sv
// --------------------
// Debug request hold-off. Masks debug requests for a fixed
// number of cycles after power-on reset so boot code can
// run first.
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module soc_debug_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  output logic debug_req_o
);

  localparam int unsigned cnt_w = $clog2(`SOC_DBG_HOLDOFF + 1);

  logic [cnt_w-1:0] cnt_q;
  logic             hold;

  assign hold = cnt_q != '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= cnt_w'(`SOC_DBG_HOLDOFF);
    end else if (hold) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = hold ? 1'b0 : debug_req_i;

endmodule

`default_nettype wire

// File: hw/soc_top.sv
// --------------------
// System shell top level. An external bus master takes the
// place of the core; reset, debug gate, boot ROM, SRAM,
// decoder and CLINT are wired together here.
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module soc_top import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     rtc_i,
  input  logic     ndmreset_i,
  input  logic     debug_req_i,
  input  logic     req_i,
  input  bus_req_t bus_req_i,
  output logic     rsp_valid_o,
  output bus_rsp_t bus_rsp_o,
  output logic     timer_irq_o,
  output logic     ipi_o,
  output logic     debug_req_o,
  output logic     core_rst_no
);

  logic                   sys_rst_n;
  logic                   rom_req, sram_req, clint_req;
  bus_req_t               tgt_req;
  logic [`SOC_DATA_W-1:0] rom_rdata, sram_rdata, clint_rdata;

  // --------------------
  // Reset and debug
  // --------------------
  soc_rst_gen i_rst_gen (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .rst_no     ( sys_rst_n  )
  );

  assign core_rst_no = sys_rst_n;

  soc_debug_gate i_debug_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

  // --------------------
  // Decoder and targets
  // --------------------
  soc_addr_decode i_addr_decode (
    .clk_i         ( clk_i       ),
    .rst_ni        ( sys_rst_n   ),
    .req_i         ( req_i       ),
    .bus_req_i     ( bus_req_i   ),
    .rom_req_o     ( rom_req     ),
    .sram_req_o    ( sram_req    ),
    .clint_req_o   ( clint_req   ),
    .bus_req_o     ( tgt_req     ),
    .rom_rdata_i   ( rom_rdata   ),
    .sram_rdata_i  ( sram_rdata  ),
    .clint_rdata_i ( clint_rdata ),
    .rsp_valid_o   ( rsp_valid_o ),
    .bus_rsp_o     ( bus_rsp_o   )
  );

  soc_bootrom i_bootrom (
    .clk_i   ( clk_i        ),
    .rst_ni  ( sys_rst_n    ),
    .req_i   ( rom_req      ),
    .addr_i  ( tgt_req.addr ),
    .rdata_o ( rom_rdata    )
  );

  // Power-on reset only, contents survive ndmreset
  soc_sram i_sram (
    .clk_i     ( clk_i      ),
    .rst_ni    ( rst_ni     ),
    .req_i     ( sram_req   ),
    .bus_req_i ( tgt_req    ),
    .rdata_o   ( sram_rdata )
  );

  soc_clint i_clint (
    .clk_i       ( clk_i       ),
    .rst_ni      ( sys_rst_n   ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .bus_req_i   ( tgt_req     ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

endmodule

`default_nettype wire

// File: test/tb_soc_top.sv
// --------------------
// Testbench for the system shell. Drives the bus master port
// on the falling edge and checks responses with assertions
// against a model kept from the memory map and register rules.
// Prints one line per test and a closing summary.
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module tb_soc_top import soc_pkg::*; ();

  localparam int unsigned max_cycles = 5000;
  localparam int unsigned holdoff    = `SOC_DBG_HOLDOFF;
  localparam int unsigned n_slots    = 16;
  localparam int unsigned n_ticks    = 12;
  localparam logic [63:0] boot_image [8] = `SOC_BOOT_IMAGE;

  logic     clk_i, rst_ni, rtc_i, ndmreset_i, debug_req_i, req_i;
  bus_req_t bus_req_i;
  logic     rsp_valid_o, timer_irq_o, ipi_o, debug_req_o, core_rst_no;
  bus_rsp_t bus_rsp_o;

  int          errors = 0;
  int          err_mark = 0;
  int          test_num = 0;
  int          failing = 0;
  int unsigned cycles = 0;
  int unsigned slot_idx [n_slots];
  logic [63:0] model [n_slots];

  soc_top UUT (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .ndmreset_i  ( ndmreset_i  ),
    .debug_req_i ( debug_req_i ),
    .req_i       ( req_i       ),
    .bus_req_i   ( bus_req_i   ),
    .rsp_valid_o ( rsp_valid_o ),
    .bus_rsp_o   ( bus_rsp_o   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .debug_req_o ( debug_req_o ),
    .core_rst_no ( core_rst_no )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // --------------------
  // Handshake checks
  // --------------------
  rsp_on_req: assert property (@(posedge clk_i) disable iff (!core_rst_no)
    req_i |=> rsp_valid_o)
    else begin
      $display("ERR %0t rsp_valid_o expected 1 actual 0", $time);
      errors++;
    end

  no_rsp_idle: assert property (@(posedge clk_i) disable iff (!core_rst_no)
    !req_i |=> !rsp_valid_o)
    else begin
      $display("ERR %0t rsp_valid_o expected 0 actual 1", $time);
      errors++;
    end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("test failed");
      $finish;
    end
  end

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp)
      else begin
        $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        errors++;
      end
  endtask

  function automatic logic [63:0] byte_merge(input logic [63:0] old_val,
                                             input logic [63:0] new_val,
                                             input logic [7:0]  be);
    logic [63:0] res;
    res = old_val;
    for (int i = 0; i < 8; i++) begin
      if (be[i]) res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  // Called on a falling edge and returns on the next one with the response
  task automatic access(input logic we, input logic [31:0] addr, input logic [7:0] be,
                        input logic [63:0] wdata, output logic [63:0] rdata,
                        output logic err);
    bus_req_t r;
    r.we             = we;
    r.addr.byte_addr = addr;
    r.be             = be;
    r.wdata          = wdata;
    bus_req_i = r;
    req_i     = 1'b1;
    @(negedge clk_i);
    req_i = 1'b0;
    rdata = bus_rsp_o.rdata;
    err   = bus_rsp_o.err;
  endtask

  task automatic check_access(input string name, input logic we, input logic [31:0] addr,
                              input logic [7:0] be, input logic [63:0] wdata,
                              input logic [63:0] exp_rdata, input logic exp_err);
    logic [63:0] rd;
    logic        err;
    access(we, addr, be, wdata, rd, err);
    check_eq({name, " rdata"}, exp_rdata, rd);
    check_eq({name, " err"}, 64'(exp_err), 64'(err));
  endtask

  task automatic rtc_pulse();
    rtc_i = 1'b1;
    repeat (4) @(negedge clk_i);
    rtc_i = 1'b0;
    repeat (4) @(negedge clk_i);
  endtask

  task automatic begin_test();
    test_num++;
    err_mark = errors;
  endtask

  task automatic report_test(input string name);
    if (errors == err_mark) begin
      $display("[%0d] %s ... ok", test_num, name);
    end else begin
      failing++;
      $display("[%0d] %s ... %0d errors", test_num, name, errors - err_mark);
    end
  endtask

  function automatic logic [31:0] slot_addr(input int slot);
    return `SOC_SRAM_BASE + 32'(slot_idx[slot] * 8);
  endfunction

  initial begin
    logic [63:0] rd, wd;
    logic        err;
    logic [7:0]  be;
    int          slot, waited;
    void'($urandom(33664));
    rst_ni      = 1'b0;
    rtc_i       = 1'b0;
    ndmreset_i  = 1'b0;
    debug_req_i = 1'b1;
    req_i       = 1'b0;
    bus_req_i   = '0;

    // --------------------
    // Reset and debug hold-off
    // --------------------
    begin_test();
    repeat (5) @(negedge clk_i);
    check_eq("rsp_valid_o", 0, rsp_valid_o);
    check_eq("timer_irq_o", 0, timer_irq_o);
    check_eq("ipi_o", 0, ipi_o);
    check_eq("debug_req_o", 0, debug_req_o);
    check_eq("core_rst_no", 0, core_rst_no);
    rst_ni = 1'b1;
    for (int c = 0; c <= holdoff + 4; c++) begin
      check_eq("debug_req_o", 64'(c >= holdoff), debug_req_o);
      @(negedge clk_i);
    end
    // Past the window the output tracks the input both ways
    debug_req_i = 1'b0;
    @(negedge clk_i);
    check_eq("debug_req_o", 0, debug_req_o);
    debug_req_i = 1'b1;
    @(negedge clk_i);
    check_eq("debug_req_o", 1, debug_req_o);
    report_test("debug hold-off");

    begin_test();
    for (int i = 0; i < 8; i++) begin
      check_access("rom read", 1'b0, `SOC_ROM_BASE + 32'(8 * i), 8'hff, '0, boot_image[i], 0);
    end
    check_access("rom write", 1'b1, `SOC_ROM_BASE + 32'h18, 8'hff, {$urandom, $urandom}, '0, 0);
    check_access("rom read", 1'b0, `SOC_ROM_BASE + 32'h18, 8'hff, '0, boot_image[3], 0);
    report_test("boot ROM");

    // --------------------
    // SRAM, back to back
    // --------------------
    begin_test();
    for (int i = 0; i < n_slots; i++) begin
      // Slots skip SRAM word 0, which the decode test overwrites
      slot_idx[i] = i * 64 + 1 + ($urandom % 63);
      model[i]    = {$urandom, $urandom};
      check_access("sram write", 1'b1, slot_addr(i), 8'hff, model[i], '0, 0);
    end
    repeat (32) begin
      slot = $urandom % n_slots;
      be   = 8'($urandom);
      wd   = {$urandom, $urandom};
      model[slot] = byte_merge(model[slot], wd, be);
      check_access("sram write", 1'b1, slot_addr(slot), be, wd, '0, 0);
    end
    for (int i = 0; i < n_slots; i++) begin
      check_access("sram read", 1'b0, slot_addr(i), 8'hff, '0, model[i], 0);
    end
    report_test("SRAM byte merge");

    begin_test();
    check_access("sram write", 1'b1, `SOC_SRAM_BASE, 8'hff, 64'h0a0b_0c0d_1122_3344, '0, 0);
    check_access("unmapped read", 1'b0, 32'h0000_0000, 8'hff, '0, '0, 1);
    check_access("unmapped read", 1'b0, 32'h1000_0000, 8'hff, '0, '0, 1);
    check_access("unmapped read", 1'b0, `SOC_ROM_BASE + `SOC_ROM_LEN, 8'hff, '0, '0, 1);
    check_access("unmapped write", 1'b1, `SOC_SRAM_BASE + `SOC_SRAM_LEN, 8'hff, '1, '0, 1);
    check_access("sram read", 1'b0, `SOC_SRAM_BASE, 8'hff, '0, 64'h0a0b_0c0d_1122_3344, 0);
    report_test("decode error");

    // --------------------
    // CLINT
    // --------------------
    begin_test();
    check_access("msip write", 1'b1, `SOC_CLINT_BASE + `SOC_CLINT_MSIP, 8'h01, 64'h1, '0, 0);
    check_eq("ipi_o", 1, ipi_o);
    check_access("msip read", 1'b0, `SOC_CLINT_BASE + `SOC_CLINT_MSIP, 8'hff, '0, 64'h1, 0);
    check_access("mtime read", 1'b0, `SOC_CLINT_BASE + `SOC_CLINT_MTIME, 8'hff, '0, '0, 0);
    check_access("mtimecmp write", 1'b1, `SOC_CLINT_BASE + `SOC_CLINT_MTIMECMP, 8'hff,
                 64'(n_ticks), '0, 0);
    check_access("mtimecmp read", 1'b0, `SOC_CLINT_BASE + `SOC_CLINT_MTIMECMP, 8'hff, '0,
                 64'(n_ticks), 0);
    check_eq("timer_irq_o", 0, timer_irq_o);
    repeat (n_ticks - 1) rtc_pulse();
    check_eq("timer_irq_o", 0, timer_irq_o);
    rtc_pulse();
    check_eq("timer_irq_o", 1, timer_irq_o);
    access(1'b0, `SOC_CLINT_BASE + `SOC_CLINT_MTIME, 8'hff, '0, rd, err);
    assert (rd >= n_ticks)
      else begin
        $display("ERR %0t mtime expected >= %0d actual %0d", $time, n_ticks, rd);
        errors++;
      end
    report_test("CLINT timer and msip");

    begin_test();
    ndmreset_i = 1'b1;
    #1;
    check_eq("core_rst_no", 0, core_rst_no);
    repeat (3) @(negedge clk_i);
    check_eq("ipi_o", 0, ipi_o);
    check_eq("timer_irq_o", 0, timer_irq_o);
    check_eq("debug_req_o", 1, debug_req_o);
    ndmreset_i = 1'b0;
    waited     = 0;
    while (!core_rst_no && waited < 8) begin
      @(negedge clk_i);
      waited++;
    end
    if (!core_rst_no) begin
      $display("core_rst_no was not released after ndmreset_i dropped");
      errors++;
    end
    check_access("msip read", 1'b0, `SOC_CLINT_BASE + `SOC_CLINT_MSIP, 8'hff, '0, '0, 0);
    check_access("mtimecmp read", 1'b0, `SOC_CLINT_BASE + `SOC_CLINT_MTIMECMP, 8'hff, '0,
                 '1, 0);
    for (int i = 0; i < n_slots; i++) begin
      check_access("sram read", 1'b0, slot_addr(i), 8'hff, '0, model[i], 0);
    end
    report_test("ndmreset");

    $display("Summary: %0d tests run, %0d failing, %0d errors", test_num, failing, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+hw
hw/soc_pkg.sv
hw/soc_rst_gen.sv
hw/soc_addr_decode.sv
hw/soc_bootrom.sv
hw/soc_sram.sv
hw/soc_clint.sv
hw/soc_debug_gate.sv
hw/soc_top.sv
test/tb_soc_top.sv
